// ==== common/exIf.sv ====
/* Operand interface between control and datapath, and the EX/MEM register
   interface with owner, watch and forwarding views */
`timescale 1ns/1ns

interface operandIf #(
    parameter int XLEN = 32
);
    exPkg::fwdSelE fwdA;          // Source of operand A
    exPkg::fwdSelE fwdB;          // Source of rs2 value
    logic useImm;                 // Operand B from immediate
    exPkg::aluOpE aluOp;          // Decoded ALU operation
    logic [XLEN-1:0] opA;         // Resolved operand A
    logic [XLEN-1:0] opB;         // Resolved operand B
    logic [XLEN-1:0] storeData;   // Forwarded rs2 for stores

    modport ctrl (output fwdA, fwdB, useImm, aluOp);
    modport dp (input fwdA, fwdB, useImm, output opA, opB, storeData);
    modport aluSide (input opA, opB, aluOp);
endinterface

interface exMemIf #(
    parameter int XLEN = 32
);
    logic valid;                  // Entry holds a real instruction
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] aluResult;   // Result or link address
    logic [XLEN-1:0] writeData;   // Store data
    logic [exPkg::REG_W-1:0] rd;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic regWrite;

    modport owner (output valid, pc, aluResult, writeData, rd,
                   memRead, memWrite, memToReg, regWrite);
    modport watch (input valid, rd, regWrite, memRead);
    modport fwd (input aluResult);
endinterface

// ==== common/exPkg.sv ====
/* Shared widths, constants and enums of the execute stage
   ALU operations, forwarding sources, branch conditions, aluOp classes */
package exPkg;

    localparam int unsigned XLEN_DEFAULT = 32;  // Datapath width
    localparam int unsigned REG_W = 5;           // Register number width
    localparam int unsigned SHAMT_W = 5;         // RV32I shift amount width
    localparam int unsigned LINK_OFFSET = 4;     // Size of one instruction

    // ALU operation after decode
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB    // LUI, immediate straight through
    } aluOpE;

    // Where an operand comes from
    typedef enum logic [1:0] {
        fromIdEx,   // Register file value
        fromExMem,  // Result one stage ahead
        fromMemWb   // Write-back value
    } fwdSelE;

    // Branch condition, encoded as its funct3
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } brCondE;

    // Two-bit aluOp class from the main decoder
    typedef enum logic [1:0] {
        memAddr = 2'b00,  // Load/store address
        branch  = 2'b01,  // Compare for branches
        regReg  = 2'b10,  // R-type
        regImm  = 2'b11   // I-type arithmetic
    } aluClassE;

endpackage

// ==== executeUnit.f ====
common/exPkg.sv
common/exIf.sv
source/exControl.sv
source/operandSelect.sv
source/alu.sv
source/branchResolve.sv
source/exMemReg.sv
source/executeUnit.sv
sim/executeUnit_props.sv
sim/executeUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f executeUnit.f \
    --top-module executeUnitTb \
    -Mdir obj_dir -o simv \
    && out=$(./obj_dir/simv) ; echo "$out" \
    && echo "$out" | grep -q "TEST RESULT: PASS" \
    && exit 0 \
    || exit 1

// ==== sim/executeUnitTb.sv ====
/* Testbench for the execute stage with shadow EX/MEM model, reference function,
   comparison process and timeout */
`timescale 1ns/1ns

module executeUnitTb;

    localparam logic [1:0] CLS_MEM = 2'd0;   // Address add
    localparam logic [1:0] CLS_BR = 2'd1;
    localparam logic [1:0] CLS_RR = 2'd2;
    localparam logic [1:0] CLS_RI = 2'd3;
    localparam int N_RANDOM = 200;
    localparam int N_FWD = 5;
    localparam int N_LOAD = 6;
    localparam int N_BRANCH = 48;
    localparam int N_JUMP = 16;
    localparam int N_STALLTEST = 40;
    localparam int MAX_STALL = 3;            // Longest memStall stretch
    localparam int LIMIT = 2 * (N_RANDOM + N_FWD + N_LOAD + N_BRANCH + N_JUMP + N_STALLTEST)
                           + N_STALLTEST * MAX_STALL + N_LOAD / 2 + 50;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [31:0] writeData;
        logic [31:0] redirectPc;
        logic [4:0] rd;
        logic memRead, memWrite, memToReg, regWrite;
        logic brInst, brTaken, mispredict;
    } expT;

    logic clk, reset_n, inValid, funct7b5, useImm, isBranch, isJump, isJalr;
    logic memRead, memWrite, memToReg, regWrite, predTaken, memWbRegWrite, memStall;
    logic [31:0] pc, readData1, readData2, immediate, predTarget, memWbData;
    logic [4:0] rs1, rs2, rd, memWbRd;
    logic [1:0] aluClass;
    logic [2:0] funct3;
    logic stallOut, exValid, exMemRead, exMemWrite, exMemToReg, exRegWrite;
    logic brInst, brTaken, mispredict;
    logic [31:0] exPc, exAluResult, exWriteData, redirectPc;
    logic [4:0] exRd;

    integer seed;
    int cycles, tries, stallLeft;
    logic stallMode, held, lastValid, bubblePending, afterBub;
    logic shValid, shRegWrite, shMemRead;    // Shadow of EX/MEM
    logic [4:0] shRd;
    logic [31:0] shResult, r, im;
    expT expQ[$];
    expT cur, lastExp;
    logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    executeUnit #(.XLEN(32)) u_dut (.*);

    bind exControl executeUnit_props u_props (
        .clk(clk), .reset_n(reset_n), .inValid(inValid), .memStall(memStall),
        .stallOut(stallOut), .accept(accept), .bubble(bubble)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            failRun("Output differs from the reference model");
        end
    endtask

    // EX/MEM before MEM/WB and never for x0
    function automatic logic [31:0] forwardValue(input logic [4:0] rs, input logic [31:0] rf);
        if (rs != 5'd0 && shValid && shRegWrite && shRd == rs) return shResult;
        if (rs != 5'd0 && memWbRegWrite && memWbRd == rs) return memWbData;
        return rf;
    endfunction

    function automatic expT refExecute(input logic [31:0] a, input logic [31:0] b2);
        expT e;
        logic [31:0] b, res, tgt, js;
        logic cond, taken;
        b = useImm ? immediate : b2;
        case (aluClass)
            CLS_MEM: res = a + b;
            CLS_BR:  res = a - b;
            default: begin
                case (funct3)
                    3'd0: res = (aluClass == CLS_RR && funct7b5) ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    3'd3: res = {31'b0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: res = funct7b5 ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
                if (aluClass == CLS_RR && useImm) res = b;   // LUI
            end
        endcase
        case (funct3)
            3'd0: cond = a == b;
            3'd1: cond = a != b;
            3'd4: cond = $signed(a) < $signed(b);
            3'd5: cond = $signed(a) >= $signed(b);
            3'd6: cond = a < b;
            3'd7: cond = a >= b;
            default: cond = 1'b0;
        endcase
        js = a + immediate;
        tgt = isJalr ? {js[31:1], 1'b0} : pc + immediate;
        taken = isJump || (isBranch && cond);
        if (isJump) e.mispredict = !predTaken || predTarget != tgt;
        else if (isBranch) e.mispredict = (taken != predTaken) || (taken && predTarget != tgt);
        else e.mispredict = 1'b0;
        e.redirectPc = taken ? tgt : pc + 32'd4;
        e.brInst = isBranch || isJump;
        e.brTaken = taken;
        e.result = isJump ? pc + 32'd4 : res;   // Jumps write the link
        e.writeData = b2;
        e.pc = pc;
        e.rd = rd;
        e.memRead = memRead;
        e.memWrite = memWrite;
        e.memToReg = memToReg;
        e.regWrite = regWrite;
        return e;
    endfunction

    // Stall decision, expected entry and shadow update for one clock
    task automatic runCycle(output logic took);
        logic loadUse, expStall, bub;
        expT e;
        #1;
        loadUse = inValid && shValid && shMemRead && shRd != 5'd0 &&
                  (shRd == rs1 || shRd == rs2) && !afterBub;
        expStall = memStall || loadUse;
        check("stallOut", 32'(stallOut), 32'(expStall));
        took = inValid && !expStall;
        bub = loadUse && !memStall;
        e = refExecute(forwardValue(rs1, readData1), forwardValue(rs2, readData2));
        if (took) expQ.push_back(e);
        if (bub) bubblePending = 1'b1;
        @(posedge clk);
        if (!memStall) begin
            afterBub = bub;
            shValid = took;
            if (took) begin
                shRd = rd;
                shRegWrite = regWrite;
                shMemRead = memRead;
                shResult = e.result;
            end
        end
    endtask

    task automatic issue(output int n);
        logic took;
        n = 0;
        took = 1'b0;
        inValid = 1'b1;
        if (stallMode && r[9]) stallLeft = int'(rnd() % MAX_STALL) + 1;
        while (!took) begin
            memStall = stallLeft > 0;
            if (stallLeft > 0) stallLeft--;
            runCycle(took);
            n++;
            if (!took) @(negedge clk);
        end
    endtask

    task automatic idle(input int n);
        logic took;
        repeat (n) begin
            @(negedge clk);
            inValid = 1'b0;
            memStall = 1'b0;
            runCycle(took);
        end
    endtask

    task automatic setInst(input logic [1:0] cls, input logic [2:0] f3, input logic f7,
                           input logic imm, input logic [4:0] s1, input logic [4:0] s2,
                           input logic [4:0] d, input logic [31:0] v1, input logic [31:0] v2,
                           input logic [31:0] iv);
        aluClass = cls;
        funct3 = f3;
        funct7b5 = f7;
        useImm = imm;
        rs1 = s1;
        rs2 = s2;
        rd = d;
        readData1 = v1;
        readData2 = v2;
        immediate = iv;
        pc = rnd() & 32'hffff_fffc;
        {memRead, memWrite, memToReg, regWrite} = 4'b0001;
        {isBranch, isJump, isJalr, predTaken} = 4'b0000;
        predTarget = 32'd0;
    endtask

    // Random R-type or I-type with random MEM/WB traffic
    task automatic randomAlu();
        logic [1:0] cls;
        r = rnd();
        cls = r[0] ? CLS_RR : CLS_RI;
        setInst(cls, r[3:1], r[4], cls == CLS_RI || r[7:5] == 3'd0, r[12:8], r[17:13],
                r[22:18], rnd(), rnd(), rnd());
        memWbRd = r[27:23];
        memWbRegWrite = r[28];
        memWbData = rnd();
    endtask

    // Compares outputs 2 ns after each rising edge
    always begin
        @(posedge clk);
        held = memStall;
        #2;
        if (reset_n) begin
            if (held) begin
                check("exValid held", 32'(exValid), 32'(lastValid));
                if (lastValid) cur = lastExp;
            end else if (expQ.size() > 0) begin
                cur = expQ.pop_front();
                check("exValid", 32'(exValid), 32'd1);
                lastExp = cur;
                lastValid = 1'b1;
            end else begin
                check("exValid", 32'(exValid), 32'd0);
                lastValid = 1'b0;
                if (bubblePending) begin   // Bubble clears every control bit
                    check("bubble controls", {28'b0, exMemRead, exMemWrite, exMemToReg,
                          exRegWrite}, 32'd0);
                end
                bubblePending = 1'b0;
            end
            if (exValid) begin
                check("exPc", exPc, cur.pc);
                check("exAluResult", exAluResult, cur.result);
                check("exWriteData", exWriteData, cur.writeData);
                check("exRd", 32'(exRd), 32'(cur.rd));
                check("exMemRead", 32'(exMemRead), 32'(cur.memRead));
                check("exMemWrite", 32'(exMemWrite), 32'(cur.memWrite));
                check("exMemToReg", 32'(exMemToReg), 32'(cur.memToReg));
                check("exRegWrite", 32'(exRegWrite), 32'(cur.regWrite));
                check("brInst", 32'(brInst), 32'(cur.brInst));
                check("brTaken", 32'(brTaken), 32'(cur.brTaken));
                check("mispredict", 32'(mispredict), 32'(cur.mispredict));
                check("redirectPc", redirectPc, cur.redirectPc);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) failRun("Timeout: the run did not finish within the cycle limit");
    end

    initial begin
        seed = 32'ha0a2;
        {reset_n, inValid, funct7b5, useImm, isBranch, isJump, isJalr} = 7'b0;
        {memRead, memWrite, memToReg, regWrite, predTaken, memWbRegWrite, memStall} = 7'b0;
        {pc, readData1, readData2, immediate, predTarget, memWbData} = '0;
        {rs1, rs2, rd, memWbRd, aluClass, funct3} = '0;
        {cycles, stallLeft, stallMode, lastValid, bubblePending, afterBub} = '0;
        {shValid, shRegWrite, shMemRead, shRd, shResult, r} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        // Quiet outputs after reset
        repeat (5) begin
            @(negedge clk);
            #1;
            check("exValid", 32'(exValid), 32'd0);
            check("stallOut", 32'(stallOut), 32'd0);
            check("exRegWrite", 32'(exRegWrite), 32'd0);
            check("exMemWrite", 32'(exMemWrite), 32'd0);
            check("mispredict", 32'(mispredict), 32'd0);
        end
        repeat (N_RANDOM) begin
            @(negedge clk);
            randomAlu();
            issue(tries);
        end
        // Forwarding priority and x0 exclusion
        @(negedge clk);
        memWbRegWrite = 1'b0;
        setInst(CLS_RI, 3'd0, 1'b0, 1'b1, 5'd1, 5'd0, 5'd3, rnd(), rnd(), rnd());
        issue(tries);
        @(negedge clk);
        {memWbRd, memWbRegWrite, memWbData} = {5'd3, 1'b1, rnd()};
        setInst(CLS_RR, 3'd0, 1'b0, 1'b0, 5'd3, 5'd3, 5'd4, rnd(), rnd(), rnd());
        issue(tries);
        @(negedge clk);
        setInst(CLS_MEM, 3'd2, 1'b0, 1'b1, 5'd4, 5'd3, 5'd0, rnd(), rnd(), rnd());
        {memWrite, regWrite} = 2'b10;   // Store data from MEM/WB
        issue(tries);
        @(negedge clk);
        setInst(CLS_RI, 3'd0, 1'b0, 1'b1, 5'd1, 5'd0, 5'd0, rnd(), rnd(), rnd());
        issue(tries);
        @(negedge clk);
        {memWbRd, memWbRegWrite} = {5'd0, 1'b1};
        setInst(CLS_MEM, 3'd2, 1'b0, 1'b1, 5'd0, 5'd0, 5'd0, rnd(), rnd(), rnd());
        {memWrite, regWrite} = 2'b10;
        issue(tries);
        // Load-use pairs
        repeat (N_LOAD / 2) begin
            @(negedge clk);
            r = rnd();
            memWbRegWrite = 1'b0;
            setInst(CLS_MEM, 3'd2, 1'b0, 1'b1, 5'd2, 5'd0, {2'b01, r[2:0]}, rnd(), rnd(), rnd());
            {memRead, memToReg} = 2'b11;
            issue(tries);
            @(negedge clk);
            {memWbRd, memWbRegWrite, memWbData} = {2'b01, r[2:0], 1'b1, rnd()};
            setInst(CLS_RR, 3'd0, 1'b0, 1'b0, r[3] ? memWbRd : 5'd2, memWbRd, 5'd30,
                    rnd(), rnd(), rnd());
            issue(tries);
            check("load-use attempts", 32'(tries), 32'd2);
        end
        // Conditional branches with random predictions
        repeat (N_BRANCH) begin
            @(negedge clk);
            memWbRegWrite = 1'b0;
            r = rnd();
            im = {{20{r[31]}}, r[30:20], 1'b0};
            setInst(CLS_BR, conds[int'(rnd() % 6)], 1'b0, 1'b0, 5'd1, 5'd2, 5'd0,
                    rnd(), rnd(), im);
            if (r[4:3] == 2'd0) readData2 = readData1;
            {regWrite, isBranch, predTaken} = {1'b0, 1'b1, r[5]};
            predTarget = r[6] ? pc + im : rnd();
            issue(tries);
        end
        repeat (N_JUMP) begin
            @(negedge clk);
            r = rnd();
            im = {{20{r[31]}}, r[30:20], 1'b0};
            setInst(CLS_MEM, 3'd0, 1'b0, r[7], 5'd1, 5'd2, 5'd20, rnd(), rnd(), im);
            {isJump, isJalr, predTaken} = {1'b1, r[7], r[5]};
            if (!r[6]) predTarget = rnd();
            else if (isJalr) predTarget = (readData1 + im) & 32'hffff_fffe;
            else predTarget = pc + im;
            issue(tries);
        end
        // Back-pressure from MEM
        stallMode = 1'b1;
        repeat (N_STALLTEST) begin
            @(negedge clk);
            randomAlu();
            issue(tries);
        end
        stallMode = 1'b0;
        idle(3);
        check("pending entries", 32'(expQ.size()), 32'd0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim/executeUnit_props.sv ====
/* Concurrent checks on stall, bubble and post-reset behavior of exControl */
`timescale 1ns/1ns

module executeUnit_props (
    input logic clk,
    input logic reset_n,
    input logic inValid,
    input logic memStall,
    input logic stallOut,
    input logic accept,
    input logic bubble
);

    logic seenValid;   // First offered instruction seen

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            seenValid <= 1'b0;
        end else if (inValid) begin
            seenValid <= 1'b1;
        end
    end

    memStallHolds: assert property (@(posedge clk) disable iff (!reset_n)
        memStall |-> stallOut) else $error("stallOut low while memStall high");

    noBubbleAccept: assert property (@(posedge clk) disable iff (!reset_n)
        !(bubble && accept)) else $error("bubble and accept in the same cycle");

    quietAfterReset: assert property (@(posedge clk) disable iff (!reset_n)
        (!seenValid && !inValid) |-> !stallOut) else $error("stallOut high before any input");

endmodule

// ==== source/alu.sv ====
/* RV32I integer ALU, arithmetic, logic, shifts and compares */
`timescale 1ns/1ns

module alu #(
    parameter int XLEN = 32
) (
    operandIf.aluSide opnd,
    output logic [XLEN-1:0] result
);

    logic [exPkg::SHAMT_W-1:0] shamt;   // Low bits of operand B
    logic signedLess;
    logic unsignedLess;

    assign shamt        = opnd.opB[exPkg::SHAMT_W-1:0];
    assign signedLess   = $signed(opnd.opA) < $signed(opnd.opB);
    assign unsignedLess = opnd.opA < opnd.opB;

    always_comb begin
        case (opnd.aluOp)
            exPkg::aluAdd:   result = opnd.opA + opnd.opB;
            exPkg::aluSub:   result = opnd.opA - opnd.opB;
            exPkg::aluSll:   result = opnd.opA << shamt;
            exPkg::aluSlt:   result = {{(XLEN-1){1'b0}}, signedLess};
            exPkg::aluSltu:  result = {{(XLEN-1){1'b0}}, unsignedLess};
            exPkg::aluXor:   result = opnd.opA ^ opnd.opB;
            exPkg::aluSrl:   result = opnd.opA >> shamt;
            exPkg::aluSra:   result = $unsigned($signed(opnd.opA) >>> shamt);
            exPkg::aluOr:    result = opnd.opA | opnd.opB;
            exPkg::aluAnd:   result = opnd.opA & opnd.opB;
            exPkg::aluPassB: result = opnd.opB;   // LUI
            default:         result = '0;
        endcase
    end

endmodule

// ==== source/branchResolve.sv ====
/* Branch condition, jump target, link address
   and misprediction check against the fetch prediction */
`timescale 1ns/1ns

module branchResolve #(
    parameter int XLEN = 32
) (
    operandIf.aluSide opnd,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] immediate,
    input  logic [2:0] funct3,
    input  logic isBranch,
    input  logic isJump,                  // JAL and JALR
    input  logic isJalr,
    input  logic predTaken,               // Fetch prediction
    input  logic [XLEN-1:0] predTarget,
    output logic brInst,
    output logic brTaken,
    output logic mispredict,
    output logic [XLEN-1:0] redirectPc,   // Correct next PC
    output logic [XLEN-1:0] linkAddr
);

    exPkg::brCondE cond;
    logic condTrue;
    logic [XLEN-1:0] jalrSum;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] fallThrough;

    assign cond = exPkg::brCondE'(funct3);

    // Compare on operands directly
    always_comb begin
        case (cond)
            exPkg::brEq:  condTrue = opnd.opA == opnd.opB;
            exPkg::brNe:  condTrue = opnd.opA != opnd.opB;
            exPkg::brLt:  condTrue = $signed(opnd.opA) < $signed(opnd.opB);
            exPkg::brGe:  condTrue = $signed(opnd.opA) >= $signed(opnd.opB);
            exPkg::brLtu: condTrue = opnd.opA < opnd.opB;
            exPkg::brGeu: condTrue = opnd.opA >= opnd.opB;
            default:      condTrue = 1'b0;   // Undefined funct3
        endcase
    end

    assign jalrSum     = opnd.opA + immediate;
    assign target      = isJalr ? {jalrSum[XLEN-1:1], 1'b0} : pc + immediate;
    assign fallThrough = pc + XLEN'(exPkg::LINK_OFFSET);
    assign linkAddr    = fallThrough;

    assign brInst  = isBranch || isJump;
    assign brTaken = isJump || (isBranch && condTrue);

    always_comb begin
        if (isJump) begin
            mispredict = !predTaken || predTarget != target;
        end else if (isBranch) begin
            mispredict = (brTaken != predTaken) || (brTaken && predTarget != target);
        end else begin
            mispredict = 1'b0;
        end
    end

    assign redirectPc = brTaken ? target : fallThrough;

endmodule

// ==== source/exControl.sv ====
/* Execute control with ALU decode, forwarding selection
   and load-use / back-pressure stall decisions */
`timescale 1ns/1ns

module exControl (
    input  logic clk,
    input  logic reset_n,
    input  logic inValid,                       // ID/EX offers an instruction
    input  logic [exPkg::REG_W-1:0] rs1,
    input  logic [exPkg::REG_W-1:0] rs2,
    input  exPkg::aluClassE aluClass,
    input  logic [2:0] funct3,
    input  logic funct7b5,
    input  logic useImmIn,
    input  logic memStall,                      // MEM stage back-pressure
    input  logic [exPkg::REG_W-1:0] memWbRd,
    input  logic memWbRegWrite,
    exMemIf.watch exMem,
    operandIf.ctrl opnd,
    output logic accept,                        // Instruction taken this edge
    output logic bubble,                        // Insert empty EX/MEM entry
    output logic stallOut                       // Hold ID/EX
);

    logic afterBubble;   // Cycle following a load-use bubble
    logic loadUse;
    logic exMemHit1;
    logic exMemHit2;
    logic memWbHit1;
    logic memWbHit2;

    // ALU operation decode
    always_comb begin
        opnd.aluOp = exPkg::aluAdd;
        case (aluClass)
            exPkg::memAddr: opnd.aluOp = exPkg::aluAdd;   // Address add
            exPkg::branch:  opnd.aluOp = exPkg::aluSub;   // Compare
            default: begin
                case (funct3)
                    3'b000: begin
                        if (aluClass == exPkg::regReg && funct7b5) begin
                            opnd.aluOp = exPkg::aluSub;
                        end else begin
                            opnd.aluOp = exPkg::aluAdd;   // ADD/ADDI
                        end
                    end
                    3'b001: opnd.aluOp = exPkg::aluSll;
                    3'b010: opnd.aluOp = exPkg::aluSlt;
                    3'b011: opnd.aluOp = exPkg::aluSltu;
                    3'b100: opnd.aluOp = exPkg::aluXor;
                    3'b101: opnd.aluOp = funct7b5 ? exPkg::aluSra : exPkg::aluSrl;
                    3'b110: opnd.aluOp = exPkg::aluOr;
                    default: opnd.aluOp = exPkg::aluAnd;
                endcase
                // Decoder marks LUI as reg-reg with immediate
                if (aluClass == exPkg::regReg && useImmIn) begin
                    opnd.aluOp = exPkg::aluPassB;
                end
            end
        endcase
    end

    assign opnd.useImm = useImmIn;

    // Register matches where x0 never forwards
    assign exMemHit1 = exMem.valid && exMem.regWrite && exMem.rd != '0 && exMem.rd == rs1;
    assign exMemHit2 = exMem.valid && exMem.regWrite && exMem.rd != '0 && exMem.rd == rs2;
    assign memWbHit1 = memWbRegWrite && memWbRd != '0 && memWbRd == rs1;
    assign memWbHit2 = memWbRegWrite && memWbRd != '0 && memWbRd == rs2;

    // EX/MEM wins over MEM/WB
    always_comb begin
        opnd.fwdA = exPkg::fromIdEx;
        opnd.fwdB = exPkg::fromIdEx;
        if (exMemHit1) opnd.fwdA = exPkg::fromExMem;
        else if (memWbHit1) opnd.fwdA = exPkg::fromMemWb;
        if (exMemHit2) opnd.fwdB = exPkg::fromExMem;
        else if (memWbHit2) opnd.fwdB = exPkg::fromMemWb;
    end

    // Load result not ready until MEM/WB
    assign loadUse = inValid && exMem.valid && exMem.memRead && !afterBubble &&
                     exMem.rd != '0 && (exMem.rd == rs1 || exMem.rd == rs2);

    assign stallOut = memStall || loadUse;
    assign bubble   = loadUse && !memStall;   // EX/MEM frozen under memStall
    assign accept   = inValid && !stallOut;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            afterBubble <= 1'b0;
        end else if (!memStall) begin
            afterBubble <= bubble;             // One stall per load
        end
    end

endmodule

// ==== source/exMemReg.sv ====
/* EX/MEM pipeline register with hold under memory stall,
   bubble insertion and registered branch outcome */
`timescale 1ns/1ns

module exMemReg #(
    parameter int XLEN = 32
) (
    input  logic clk,
    input  logic reset_n,
    input  logic accept,
    input  logic bubble,
    input  logic memStall,
    input  logic [XLEN-1:0] aluResult,
    input  logic [XLEN-1:0] linkAddr,
    input  logic isJump,
    input  logic [XLEN-1:0] storeData,
    input  logic [XLEN-1:0] pc,
    input  logic [exPkg::REG_W-1:0] rd,
    input  logic memRead,
    input  logic memWrite,
    input  logic memToReg,
    input  logic regWrite,
    input  logic brInst,
    input  logic brTaken,
    input  logic mispredict,
    input  logic [XLEN-1:0] redirectPc,
    exMemIf.owner exMem,
    output logic brInstQ,
    output logic brTakenQ,
    output logic mispredictQ,
    output logic [XLEN-1:0] redirectPcQ
);

    // Control bits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exMem.valid    <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
            exMem.regWrite <= 1'b0;
            brInstQ        <= 1'b0;
            brTakenQ       <= 1'b0;
            mispredictQ    <= 1'b0;
        end else if (!memStall) begin           // Hold while MEM is stalled
            if (accept) begin
                exMem.valid    <= 1'b1;
                exMem.memRead  <= memRead;
                exMem.memWrite <= memWrite;
                exMem.memToReg <= memToReg;
                exMem.regWrite <= regWrite;
                brInstQ        <= brInst;
                brTakenQ       <= brTaken;
                mispredictQ    <= mispredict;
            end else begin
                exMem.valid <= 1'b0;
                brInstQ     <= 1'b0;
                brTakenQ    <= 1'b0;
                mispredictQ <= 1'b0;
                if (bubble) begin               // Load-use slot, all control off
                    exMem.memRead  <= 1'b0;
                    exMem.memWrite <= 1'b0;
                    exMem.memToReg <= 1'b0;
                    exMem.regWrite <= 1'b0;
                end
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept && !memStall) begin
            exMem.pc        <= pc;
            exMem.aluResult <= isJump ? linkAddr : aluResult;   // Jumps write link
            exMem.writeData <= storeData;
            exMem.rd        <= rd;
            redirectPcQ     <= redirectPc;
        end
    end

endmodule

// ==== source/executeUnit.sv ====
/* RV32I execute stage top, control, operand select, ALU,
   branch resolution and EX/MEM register behind plain ports */
`timescale 1ns/1ns

module executeUnit #(
    parameter int XLEN = exPkg::XLEN_DEFAULT
) (
    input  logic clk,
    input  logic reset_n,
    input  logic inValid,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] readData1,
    input  logic [XLEN-1:0] readData2,
    input  logic [XLEN-1:0] immediate,
    input  logic [exPkg::REG_W-1:0] rs1,
    input  logic [exPkg::REG_W-1:0] rs2,
    input  logic [exPkg::REG_W-1:0] rd,
    input  logic [1:0] aluClass,
    input  logic [2:0] funct3,
    input  logic funct7b5,
    input  logic useImm,
    input  logic isBranch,
    input  logic isJump,
    input  logic isJalr,
    input  logic memRead,
    input  logic memWrite,
    input  logic memToReg,
    input  logic regWrite,
    input  logic predTaken,
    input  logic [XLEN-1:0] predTarget,
    input  logic [exPkg::REG_W-1:0] memWbRd,
    input  logic memWbRegWrite,
    input  logic [XLEN-1:0] memWbData,
    input  logic memStall,
    output logic stallOut,
    output logic exValid,
    output logic [XLEN-1:0] exPc,
    output logic [XLEN-1:0] exAluResult,
    output logic [XLEN-1:0] exWriteData,
    output logic [exPkg::REG_W-1:0] exRd,
    output logic exMemRead,
    output logic exMemWrite,
    output logic exMemToReg,
    output logic exRegWrite,
    output logic brInst,
    output logic brTaken,
    output logic mispredict,
    output logic [XLEN-1:0] redirectPc
);

    logic accept;
    logic bubble;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] linkAddr;
    logic brInstComb;
    logic brTakenComb;
    logic mispredictComb;
    logic [XLEN-1:0] redirectPcComb;

    operandIf #(.XLEN(XLEN)) opndBus ();
    exMemIf #(.XLEN(XLEN)) exMemBus ();

    exControl u_control (
        .clk(clk), .reset_n(reset_n), .inValid(inValid), .rs1(rs1), .rs2(rs2),
        .aluClass(exPkg::aluClassE'(aluClass)), .funct3(funct3), .funct7b5(funct7b5),
        .useImmIn(useImm), .memStall(memStall), .memWbRd(memWbRd),
        .memWbRegWrite(memWbRegWrite), .exMem(exMemBus), .opnd(opndBus),
        .accept(accept), .bubble(bubble), .stallOut(stallOut)
    );

    operandSelect #(.XLEN(XLEN)) u_operandSelect (
        .opnd(opndBus), .exMem(exMemBus), .readData1(readData1), .readData2(readData2),
        .immediate(immediate), .memWbData(memWbData)
    );

    alu #(.XLEN(XLEN)) u_alu (.opnd(opndBus), .result(aluResult));

    branchResolve #(.XLEN(XLEN)) u_branchResolve (
        .opnd(opndBus), .pc(pc), .immediate(immediate), .funct3(funct3),
        .isBranch(isBranch), .isJump(isJump), .isJalr(isJalr), .predTaken(predTaken),
        .predTarget(predTarget), .brInst(brInstComb), .brTaken(brTakenComb),
        .mispredict(mispredictComb), .redirectPc(redirectPcComb), .linkAddr(linkAddr)
    );

    exMemReg #(.XLEN(XLEN)) u_exMemReg (
        .clk(clk), .reset_n(reset_n), .accept(accept), .bubble(bubble),
        .memStall(memStall), .aluResult(aluResult), .linkAddr(linkAddr), .isJump(isJump),
        .storeData(opndBus.storeData), .pc(pc), .rd(rd), .memRead(memRead),
        .memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite),
        .brInst(brInstComb), .brTaken(brTakenComb), .mispredict(mispredictComb),
        .redirectPc(redirectPcComb), .exMem(exMemBus), .brInstQ(brInst),
        .brTakenQ(brTaken), .mispredictQ(mispredict), .redirectPcQ(redirectPc)
    );

    // EX/MEM contents out to MEM stage
    assign exValid     = exMemBus.valid;
    assign exPc        = exMemBus.pc;
    assign exAluResult = exMemBus.aluResult;
    assign exWriteData = exMemBus.writeData;
    assign exRd        = exMemBus.rd;
    assign exMemRead   = exMemBus.memRead;
    assign exMemWrite  = exMemBus.memWrite;
    assign exMemToReg  = exMemBus.memToReg;
    assign exRegWrite  = exMemBus.regWrite;

endmodule

// ==== source/operandSelect.sv ====
/* Forwarding multiplexers for both operands and store data,
   immediate selection for operand B */
`timescale 1ns/1ns

module operandSelect #(
    parameter int XLEN = 32
) (
    operandIf.dp opnd,
    exMemIf.fwd exMem,
    input  logic [XLEN-1:0] readData1,   // rs1 from register file
    input  logic [XLEN-1:0] readData2,   // rs2 from register file
    input  logic [XLEN-1:0] immediate,
    input  logic [XLEN-1:0] memWbData    // Write-back value
);

    logic [XLEN-1:0] rs2Value;   // Forwarded rs2

    always_comb begin
        case (opnd.fwdA)
            exPkg::fromExMem: opnd.opA = exMem.aluResult;
            exPkg::fromMemWb: opnd.opA = memWbData;
            default:          opnd.opA = readData1;
        endcase
        case (opnd.fwdB)
            exPkg::fromExMem: rs2Value = exMem.aluResult;
            exPkg::fromMemWb: rs2Value = memWbData;
            default:          rs2Value = readData2;
        endcase
    end

    assign opnd.opB       = opnd.useImm ? immediate : rs2Value;
    assign opnd.storeData = rs2Value;   // Stores always take rs2

endmodule
